/* rtl/panel_defs.svh */
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// Panel geometry, two halves share one row address
`define PANEL_COLS      32
`define PANEL_SCAN_ROWS 8

// Encoder position wraps past this value
`define QUAD_COUNT_MAX  23

// APB register map
`define APB_ADDR_W      12
`define REG_CTRL        12'h000
`define REG_STATUS      12'h004

// Pixel i = row*32 + col lives at PIX_BASE + 4*i
`define PIX_BASE        12'h400

`endif

/* rtl/panel_pkg.sv */
`include "panel_defs.svh"

package panel_pkg;

  // {red, green, blue}
  typedef logic [2:0] pixel_t;

  typedef logic [4:0] col_t;
  typedef logic [2:0] scan_row_t;

  // {scan row, column}
  typedef logic [7:0] fb_addr_t;

  typedef logic [4:0] count_t;

  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0]            apb_data_t;

  typedef enum logic [1:0] {
    SHIFT_LOW,
    SHIFT_HIGH,
    BLANK,
    LATCH
  } shift_state_e;

endpackage

/* rtl/quad_decoder.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module quad_decoder (
  input  logic              clk,
  input  logic              rst,
  input  logic              quad_a,
  input  logic              quad_b,
  output panel_pkg::count_t count
);

  localparam panel_pkg::count_t COUNT_MAX = panel_pkg::count_t'(`QUAD_COUNT_MAX);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_prev;
  logic       rise;

  // Edge flop holds the previous synchronised level
  assign rise = a_sync[1] && !a_prev;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_sync <= '0;
      b_sync <= '0;
      a_prev <= 1'b0;
      count  <= '0;
    end else begin
      a_sync <= {a_sync[0], quad_a};
      b_sync <= {b_sync[0], quad_b};
      a_prev <= a_sync[1];

      if (rise) begin
        if (!b_sync[1]) begin
          if (count == COUNT_MAX) begin
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end else begin
          if (count == '0) begin
            count <= COUNT_MAX;
          end else begin
            count <= count - 1'b1;
          end
        end
      end
    end
  end

endmodule

/* rtl/panel_apb_regs.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module panel_apb_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  panel_pkg::apb_addr_t paddr,
  input  panel_pkg::apb_data_t pwdata,
  output panel_pkg::apb_data_t prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  panel_pkg::count_t    count,
  output logic                 scan_en,
  output logic                 blank,
  output logic                 wr_en,
  output panel_pkg::fb_addr_t  wr_addr,
  output logic                 wr_half,
  output panel_pkg::pixel_t    wr_pixel,
  output panel_pkg::fb_addr_t  rd_a_addr,
  output logic                 rd_a_half,
  input  panel_pkg::pixel_t    rd_a_pixel
);

  localparam int PIX_BYTES = 2 * `PANEL_SCAN_ROWS * `PANEL_COLS * 4;

  panel_pkg::apb_addr_t pix_off;
  logic                 hit_ctrl;
  logic                 hit_status;
  logic                 hit_pix;
  logic                 pix_read;
  logic                 wait_q;

  assign pix_off    = paddr - `PIX_BASE;
  assign hit_ctrl   = (paddr == `REG_CTRL);
  assign hit_status = (paddr == `REG_STATUS);
  assign hit_pix    = (paddr >= `PIX_BASE) && (pix_off < PIX_BYTES);

  // Bit 10 picks the half, bits 9:2 are {scan row, column}
  assign wr_addr   = pix_off[9:2];
  assign wr_half   = pix_off[10];
  assign wr_pixel  = pwdata[2:0];
  assign rd_a_addr = pix_off[9:2];
  assign rd_a_half = pix_off[10];

  assign wr_en    = psel && penable && pwrite && hit_pix;
  assign pix_read = psel && !pwrite && hit_pix;

  // Memory read needs one extra cycle
  assign pready  = psel && penable && (!pix_read || wait_q);
  assign pslverr = pready && !(hit_ctrl || hit_status || hit_pix);

  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[1:0] = {blank, scan_en};
    end else if (hit_status) begin
      prdata[4:0] = count;
    end else if (hit_pix) begin
      prdata[2:0] = rd_a_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q  <= 1'b0;
      scan_en <= 1'b0;
      blank   <= 1'b0;
    end else begin
      wait_q <= psel && penable && pix_read && !wait_q;
      if (psel && penable && pwrite && hit_ctrl) begin
        scan_en <= pwdata[0];
        blank   <= pwdata[1];
      end
    end
  end

endmodule

/* rtl/frame_mem.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module frame_mem (
  input  logic                clk,
  input  logic                wr_en,
  input  logic                wr_half,
  input  panel_pkg::fb_addr_t wr_addr,
  input  panel_pkg::pixel_t   wr_pixel,
  input  panel_pkg::fb_addr_t rd_a_addr,
  input  logic                rd_a_half,
  output panel_pkg::pixel_t   rd_a_pixel,
  input  panel_pkg::fb_addr_t addr_b,
  output panel_pkg::pixel_t   pixel_upper,
  output panel_pkg::pixel_t   pixel_lower
);

  localparam int DEPTH = `PANEL_SCAN_ROWS * `PANEL_COLS;

  // Rows 0-7 and rows 8-15
  panel_pkg::pixel_t mem_upper [DEPTH];
  panel_pkg::pixel_t mem_lower [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en && !wr_half) begin
      mem_upper[wr_addr] <= wr_pixel;
    end
    if (wr_en && wr_half) begin
      mem_lower[wr_addr] <= wr_pixel;
    end
  end

  always_ff @(posedge clk) begin
    rd_a_pixel  <= rd_a_half ? mem_lower[rd_a_addr] : mem_upper[rd_a_addr];
    pixel_upper <= mem_upper[addr_b];
    pixel_lower <= mem_lower[addr_b];
  end

endmodule

/* rtl/scan_sequencer.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module scan_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 scan_en,
  input  logic                 busy,
  output panel_pkg::fb_addr_t  addr_b,
  output logic                 col_valid,
  output logic                 row_done,
  output panel_pkg::scan_row_t scan_row
);

  localparam panel_pkg::col_t      LAST_COL = panel_pkg::col_t'(`PANEL_COLS - 1);
  localparam panel_pkg::scan_row_t LAST_ROW = panel_pkg::scan_row_t'(`PANEL_SCAN_ROWS - 1);

  panel_pkg::col_t      col;
  panel_pkg::scan_row_t row;
  logic                 phase;
  logic                 run;
  logic                 issue;

  // A started row always runs to column 31
  assign run    = scan_en || phase || (col != '0);
  assign issue  = run && !phase && !busy;
  assign addr_b = {row, col};

  always_ff @(posedge clk) begin
    if (rst) begin
      col       <= '0;
      row       <= '0;
      phase     <= 1'b0;
      col_valid <= 1'b0;
      row_done  <= 1'b0;
      scan_row  <= '0;
    end else begin
      // Flags trail the address by the memory read
      col_valid <= issue;
      row_done  <= issue && (col == LAST_COL);
      scan_row  <= row;

      if (run && !busy) begin
        phase <= !phase;
        if (phase) begin
          if (col == LAST_COL) begin
            col <= '0;
            if (row == LAST_ROW) begin
              row <= '0;
            end else begin
              row <= row + 1'b1;
            end
          end else begin
            col <= col + 1'b1;
          end
        end
      end else if (!run) begin
        // Restart from row 0 once stopped
        row <= '0;
      end
    end
  end

endmodule

/* rtl/panel_shifter.sv */
`timescale 1ns/1ns

module panel_shifter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 blank,
  input  logic                 col_valid,
  input  logic                 row_done,
  input  panel_pkg::scan_row_t scan_row,
  input  panel_pkg::pixel_t    pixel_upper,
  input  panel_pkg::pixel_t    pixel_lower,
  output panel_pkg::pixel_t    rgb0,
  output panel_pkg::pixel_t    rgb1,
  output logic                 rgb_clk,
  output logic                 rgb_stb,
  output logic                 oe_n,
  output panel_pkg::scan_row_t row_sel,
  output logic                 busy
);

  panel_pkg::shift_state_e state;
  logic                    col_live;
  logic                    latch_pend;
  logic                    buf_valid;
  panel_pkg::pixel_t       buf_upper;
  panel_pkg::pixel_t       buf_lower;
  panel_pkg::scan_row_t    latch_row;

  assign busy = (state == panel_pkg::BLANK) || (state == panel_pkg::LATCH);

  // Display on only while a column is shifting
  assign oe_n = blank || !((state == panel_pkg::SHIFT_HIGH) ||
                           ((state == panel_pkg::SHIFT_LOW) && col_live));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= panel_pkg::SHIFT_LOW;
      col_live   <= 1'b0;
      latch_pend <= 1'b0;
      buf_valid  <= 1'b0;
      rgb0       <= '0;
      rgb1       <= '0;
      rgb_clk    <= 1'b0;
      rgb_stb    <= 1'b0;
      row_sel    <= '0;
    end else begin
      rgb_stb <= 1'b0;
      if (col_valid && row_done) begin
        latch_pend <= 1'b1;
        latch_row  <= scan_row;
      end

      case (state)
        panel_pkg::SHIFT_LOW: begin
          if (col_live) begin
            state   <= panel_pkg::SHIFT_HIGH;
            rgb_clk <= 1'b1;
          end else if (col_valid) begin
            rgb0     <= pixel_upper;
            rgb1     <= pixel_lower;
            col_live <= 1'b1;
          end
        end
        panel_pkg::SHIFT_HIGH: begin
          rgb_clk <= 1'b0;
          if (latch_pend) begin
            state    <= panel_pkg::BLANK;
            col_live <= 1'b0;
          end else begin
            state    <= panel_pkg::SHIFT_LOW;
            col_live <= col_valid;
            if (col_valid) begin
              rgb0 <= pixel_upper;
              rgb1 <= pixel_lower;
            end
          end
        end
        panel_pkg::BLANK: begin
          state      <= panel_pkg::LATCH;
          rgb_stb    <= 1'b1;
          row_sel    <= latch_row;
          latch_pend <= 1'b0;
        end
        default: begin
          state     <= panel_pkg::SHIFT_LOW;
          col_live  <= buf_valid;
          buf_valid <= 1'b0;
          if (buf_valid) begin
            rgb0 <= buf_upper;
            rgb1 <= buf_lower;
          end
        end
      endcase

      // First column of the next row waits out blank and latch
      if (col_valid && ((state == panel_pkg::BLANK) ||
                        ((state == panel_pkg::SHIFT_HIGH) && latch_pend))) begin
        buf_valid <= 1'b1;
        buf_upper <= pixel_upper;
        buf_lower <= pixel_lower;
      end
    end
  end

endmodule

/* rtl/rgb_panel_top.sv */
`timescale 1ns/1ns

module rgb_panel_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  panel_pkg::apb_addr_t paddr,
  input  panel_pkg::apb_data_t pwdata,
  output panel_pkg::apb_data_t prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic                 quad_a,
  input  logic                 quad_b,
  output panel_pkg::pixel_t    rgb_ind,
  output panel_pkg::pixel_t    rgb0,
  output panel_pkg::pixel_t    rgb1,
  output logic                 rgb_clk,
  output logic                 rgb_stb,
  output logic                 oe_n,
  output panel_pkg::scan_row_t row_sel
);

  panel_pkg::count_t    count;
  logic                 scan_en;
  logic                 blank;
  logic                 wr_en;
  panel_pkg::fb_addr_t  wr_addr;
  logic                 wr_half;
  panel_pkg::pixel_t    wr_pixel;
  panel_pkg::fb_addr_t  rd_a_addr;
  logic                 rd_a_half;
  panel_pkg::pixel_t    rd_a_pixel;
  panel_pkg::fb_addr_t  addr_b;
  panel_pkg::pixel_t    pixel_upper;
  panel_pkg::pixel_t    pixel_lower;
  logic                 col_valid;
  logic                 row_done;
  panel_pkg::scan_row_t scan_row;
  logic                 busy;

  // Indicator shows the low bits of the position
  assign rgb_ind = count[2:0];

  quad_decoder u_quad (
    .clk    (clk),
    .rst    (rst),
    .quad_a (quad_a),
    .quad_b (quad_b),
    .count  (count)
  );

  panel_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .count      (count),
    .scan_en    (scan_en),
    .blank      (blank),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_half    (wr_half),
    .wr_pixel   (wr_pixel),
    .rd_a_addr  (rd_a_addr),
    .rd_a_half  (rd_a_half),
    .rd_a_pixel (rd_a_pixel)
  );

  frame_mem u_mem (
    .clk         (clk),
    .wr_en       (wr_en),
    .wr_half     (wr_half),
    .wr_addr     (wr_addr),
    .wr_pixel    (wr_pixel),
    .rd_a_addr   (rd_a_addr),
    .rd_a_half   (rd_a_half),
    .rd_a_pixel  (rd_a_pixel),
    .addr_b      (addr_b),
    .pixel_upper (pixel_upper),
    .pixel_lower (pixel_lower)
  );

  scan_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .scan_en   (scan_en),
    .busy      (busy),
    .addr_b    (addr_b),
    .col_valid (col_valid),
    .row_done  (row_done),
    .scan_row  (scan_row)
  );

  panel_shifter u_shift (
    .clk         (clk),
    .rst         (rst),
    .blank       (blank),
    .col_valid   (col_valid),
    .row_done    (row_done),
    .scan_row    (scan_row),
    .pixel_upper (pixel_upper),
    .pixel_lower (pixel_lower),
    .rgb0        (rgb0),
    .rgb1        (rgb1),
    .rgb_clk     (rgb_clk),
    .rgb_stb     (rgb_stb),
    .oe_n        (oe_n),
    .row_sel     (row_sel),
    .busy        (busy)
  );

endmodule

/* sim/rgb_panel_props.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module rgb_panel_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 psel,
  input logic                 penable,
  input logic                 pready,
  input logic                 pslverr,
  input logic                 rgb_stb,
  input logic                 oe_n,
  input panel_pkg::scan_row_t row_sel,
  input panel_pkg::count_t    count
);

  int fail_count = 0;

  // Latch only while the display is dark
  a_stb_dark: assert property (@(posedge clk) disable iff (rst) rgb_stb |-> oe_n)
    else begin
      fail_count++;
      $error("rgb_stb high while oe_n is low");
    end

  // A stalled pixel read completes cleanly in the next cycle
  a_one_wait: assert property (@(posedge clk) disable iff (rst)
                               (psel && penable && !pready) |=>
                               (psel && penable && pready && !pslverr))
    else begin
      fail_count++;
      $error("pixel read wait state did not end after one cycle");
    end

  a_count_range: assert property (@(posedge clk) disable iff (rst)
                                  count <= panel_pkg::count_t'(`QUAD_COUNT_MAX))
    else begin
      fail_count++;
      $error("encoder count above its maximum");
    end

  // Row select moves only with the latch strobe
  a_row_sel_stable: assert property (@(posedge clk) disable iff (rst)
                                     !$stable(row_sel) |-> rgb_stb)
    else begin
      fail_count++;
      $error("row_sel changed without rgb_stb");
    end

endmodule

/* sim/rgb_panel_tb.sv */
`timescale 1ns/1ns
`include "panel_defs.svh"

module rgb_panel_tb;

  localparam int NUM_PIXELS = 2 * `PANEL_SCAN_ROWS * `PANEL_COLS;
  localparam int ROW_CYCLES = 2 * `PANEL_COLS + 2;
  localparam int APB_CYCLES = 5;
  // Fill and readback are the longest entries
  localparam int LONGEST_OP = NUM_PIXELS * APB_CYCLES;

  typedef enum int {
    OP_WRITE,
    OP_READ,
    OP_IDLE_PINS,
    OP_FILL,
    OP_READBACK,
    OP_ENCODER,
    OP_SCAN,
    OP_STOP
  } op_e;

  typedef struct packed {
    op_e                  op;
    panel_pkg::apb_addr_t addr;
    panel_pkg::apb_data_t data;
    logic                 err;
    int                   steps;
    logic                 flag;
  } entry_t;

  logic                 clk;
  logic                 rst;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  panel_pkg::apb_addr_t paddr;
  panel_pkg::apb_data_t pwdata;
  panel_pkg::apb_data_t prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 quad_a;
  logic                 quad_b;
  panel_pkg::pixel_t    rgb_ind;
  panel_pkg::pixel_t    rgb0;
  panel_pkg::pixel_t    rgb1;
  logic                 rgb_clk;
  logic                 rgb_stb;
  logic                 oe_n;
  panel_pkg::scan_row_t row_sel;

  panel_pkg::pixel_t model [NUM_PIXELS];
  panel_pkg::count_t model_count;
  entry_t            tests [$];
  int                seed;
  int                cycles = 0;
  int                cycle_limit = 0;

  rgb_panel_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .quad_a  (quad_a),
    .quad_b  (quad_b),
    .rgb_ind (rgb_ind),
    .rgb0    (rgb0),
    .rgb1    (rgb1),
    .rgb_clk (rgb_clk),
    .rgb_stb (rgb_stb),
    .oe_n    (oe_n),
    .row_sel (row_sel)
  );

  bind rgb_panel_top rgb_panel_props u_props (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .rgb_stb (rgb_stb),
    .oe_n    (oe_n),
    .row_sel (row_sel),
    .count   (count)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      stop_with_failure();
    end else if (u_dut.u_props.fail_count != 0) begin
      $display("A bound assertion failed at %0t", $time);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input panel_pkg::apb_data_t exp,
                            input panel_pkg::apb_data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input panel_pkg::count_t exp,
                             input panel_pkg::count_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_pixel(input string name, input panel_pkg::pixel_t exp,
                             input panel_pkg::pixel_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_row(input string name, input panel_pkg::scan_row_t exp,
                           input panel_pkg::scan_row_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic fail_with(input string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  function automatic panel_pkg::count_t next_count(input panel_pkg::count_t c,
                                                   input logic down);
    if (!down) begin
      return (c == `QUAD_COUNT_MAX) ? 5'd0 : c + 5'd1;
    end
    return (c == 5'd0) ? panel_pkg::count_t'(`QUAD_COUNT_MAX) : c - 5'd1;
  endfunction

  function automatic panel_pkg::apb_addr_t pixel_addr(input int i);
    return panel_pkg::apb_addr_t'(`PIX_BASE + 4 * i);
  endfunction

  function automatic logic is_pixel_addr(input panel_pkg::apb_addr_t addr);
    return (addr >= `PIX_BASE) && (int'(addr) < int'(`PIX_BASE) + 4 * NUM_PIXELS);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic apb_transfer(input logic write, input panel_pkg::apb_addr_t addr,
                              input panel_pkg::apb_data_t wdata,
                              output panel_pkg::apb_data_t rdata, output logic err,
                              output int waits);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      if (waits > 4) begin
        fail_with($sformatf("APB transfer to %h never completed", addr));
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input panel_pkg::apb_addr_t addr,
                           input panel_pkg::apb_data_t data, input logic exp_err);
    panel_pkg::apb_data_t rdata;
    logic                 err;
    int                   waits;
    apb_transfer(1'b1, addr, data, rdata, err, waits);
    check_bit("pslverr", exp_err, err);
    if (waits != 0) begin
      fail_with($sformatf("Write to %h took %0d wait states instead of none", addr, waits));
    end
  endtask

  task automatic read_reg(input panel_pkg::apb_addr_t addr,
                          output panel_pkg::apb_data_t rdata, output logic err);
    int waits;
    int exp_waits;
    exp_waits = is_pixel_addr(addr) ? 1 : 0;
    apb_transfer(1'b0, addr, '0, rdata, err, waits);
    if (waits != exp_waits) begin
      fail_with($sformatf("Read of %h took %0d wait states, expected %0d",
                          addr, waits, exp_waits));
    end
  endtask

  // Count moves on the third clock after the quad_a rise
  task automatic encoder_step(input logic down);
    quad_b = down;
    wait_cycles(3);
    quad_a = 1'b1;
    wait_cycles(2);
    check_pixel("rgb_ind", model_count[2:0], rgb_ind);
    model_count = next_count(model_count, down);
    wait_cycles(1);
    check_pixel("rgb_ind", model_count[2:0], rgb_ind);
    wait_cycles(1);
    quad_a = 1'b0;
    wait_cycles(3);
  endtask

  // Samples at falling edges, well away from the register updates
  task automatic watch_row(input int r, input logic blanked);
    int   col;
    int   waits;
    logic clk_prev;
    logic latched;
    col      = 0;
    waits    = 0;
    clk_prev = rgb_clk;
    latched  = 1'b0;
    while (!latched) begin
      @(negedge clk);
      waits++;
      if (waits > 2 * ROW_CYCLES) begin
        fail_with($sformatf("Row %0d was not shifted and latched in time", r));
      end
      if (blanked) begin
        check_bit("oe_n", 1'b1, oe_n);
      end
      if (rgb_clk && !clk_prev) begin
        if (col >= `PANEL_COLS) begin
          fail_with($sformatf("Row %0d got more than %0d shift clocks", r, `PANEL_COLS));
        end
        check_pixel("rgb0", model[r * `PANEL_COLS + col], rgb0);
        check_pixel("rgb1", model[(r + `PANEL_SCAN_ROWS) * `PANEL_COLS + col], rgb1);
        if (!blanked) begin
          check_bit("oe_n", 1'b0, oe_n);
        end
        col++;
      end
      if (rgb_stb) begin
        if (col != `PANEL_COLS) begin
          fail_with($sformatf("Row %0d latched after %0d shift clocks", r, col));
        end
        check_row("row_sel", panel_pkg::scan_row_t'(r), row_sel);
        latched = 1'b1;
      end
      clk_prev = rgb_clk;
    end
  endtask

  task automatic stop_scan();
    int waits;
    int rises;
    write_reg(`REG_CTRL, '0, 1'b0);
    waits = 0;
    @(negedge clk);
    while (!rgb_stb) begin
      waits++;
      if (waits > 2 * ROW_CYCLES) begin
        fail_with("The row in progress never latched after scan_en was cleared");
      end
      @(negedge clk);
    end
    // The unfinished row was the first one of the next frame
    check_row("row_sel", '0, row_sel);
    rises = 0;
    repeat (2 * ROW_CYCLES) begin
      @(negedge clk);
      if (rgb_clk) begin
        rises++;
      end
      check_bit("oe_n", 1'b1, oe_n);
    end
    if (rises != 0) begin
      fail_with("The shift clock kept running after the scan stopped");
    end
  endtask

  task automatic run_entry(input entry_t e);
    panel_pkg::apb_data_t rdata;
    panel_pkg::apb_data_t wdata;
    logic                 err;
    case (e.op)
      OP_WRITE: begin
        write_reg(e.addr, e.data, e.err);
      end
      OP_READ: begin
        read_reg(e.addr, rdata, err);
        check_bit("pslverr", e.err, err);
        check_data("prdata", e.data, rdata);
      end
      OP_IDLE_PINS: begin
        check_bit("oe_n", 1'b1, oe_n);
        check_bit("rgb_stb", 1'b0, rgb_stb);
        check_bit("rgb_clk", 1'b0, rgb_clk);
        check_row("row_sel", '0, row_sel);
        check_pixel("rgb0", '0, rgb0);
        check_pixel("rgb1", '0, rgb1);
        check_pixel("rgb_ind", '0, rgb_ind);
      end
      OP_FILL: begin
        // Upper data bits are random too and must be dropped
        for (int i = 0; i < NUM_PIXELS; i++) begin
          wdata    = $random(seed);
          model[i] = wdata[2:0];
          write_reg(pixel_addr(i), wdata, 1'b0);
        end
      end
      OP_READBACK: begin
        for (int i = 0; i < NUM_PIXELS; i++) begin
          read_reg(pixel_addr(i), rdata, err);
          check_bit("pslverr", 1'b0, err);
          check_data("prdata", {29'd0, model[i]}, rdata);
        end
      end
      OP_ENCODER: begin
        wait_cycles(1);
        for (int n = 0; n < e.steps; n++) begin
          encoder_step(e.flag);
        end
        read_reg(`REG_STATUS, rdata, err);
        check_bit("pslverr", 1'b0, err);
        check_count("STATUS.count", model_count, rdata[4:0]);
        check_data("STATUS", {27'd0, model_count}, rdata);
        check_pixel("rgb_ind", model_count[2:0], rgb_ind);
      end
      OP_SCAN: begin
        write_reg(`REG_CTRL, {30'd0, e.flag, 1'b1}, 1'b0);
        for (int r = 0; r < `PANEL_SCAN_ROWS; r++) begin
          watch_row(r, e.flag);
        end
      end
      default: begin
        stop_scan();
      end
    endcase
  endtask

  task automatic add_test(input op_e op, input panel_pkg::apb_addr_t addr,
                          input panel_pkg::apb_data_t data, input logic err,
                          input int steps, input logic flag);
    entry_t e;
    e.op    = op;
    e.addr  = addr;
    e.data  = data;
    e.err   = err;
    e.steps = steps;
    e.flag  = flag;
    tests.push_back(e);
  endtask

  task automatic build_tests();
    add_test(OP_IDLE_PINS, '0,          '0,    1'b0, 0, 1'b0);
    add_test(OP_READ,      `REG_CTRL,   '0,    1'b0, 0, 1'b0);
    add_test(OP_READ,      `REG_STATUS, '0,    1'b0, 0, 1'b0);
    add_test(OP_WRITE,     `REG_CTRL,   32'h2, 1'b0, 0, 1'b0);
    add_test(OP_READ,      `REG_CTRL,   32'h2, 1'b0, 0, 1'b0);
    add_test(OP_WRITE,     `REG_CTRL,   '0,    1'b0, 0, 1'b0);
    add_test(OP_FILL,      '0,          '0,    1'b0, 0, 1'b0);
    add_test(OP_READBACK,  '0,          '0,    1'b0, 0, 1'b0);
    // Unmapped space on both sides of the pixel window
    add_test(OP_READ,      12'h008,     '0,    1'b1, 0, 1'b0);
    add_test(OP_READ,      12'h3fc,     '0,    1'b1, 0, 1'b0);
    add_test(OP_READ,      12'hc00,     '0,    1'b1, 0, 1'b0);
    add_test(OP_WRITE,     12'hffc,     32'h5, 1'b1, 0, 1'b0);
    add_test(OP_WRITE,     `REG_STATUS, 32'h1f, 1'b0, 0, 1'b0);
    add_test(OP_READ,      `REG_STATUS, '0,    1'b0, 0, 1'b0);
    // 0 up to 5, down through 0 to 22, up through 23 to 1, down to 23
    add_test(OP_ENCODER,   '0,          '0,    1'b0, 5, 1'b0);
    add_test(OP_ENCODER,   '0,          '0,    1'b0, 7, 1'b1);
    add_test(OP_ENCODER,   '0,          '0,    1'b0, 3, 1'b0);
    add_test(OP_ENCODER,   '0,          '0,    1'b0, 2, 1'b1);
    add_test(OP_SCAN,      '0,          '0,    1'b0, 0, 1'b0);
    add_test(OP_STOP,      '0,          '0,    1'b0, 0, 1'b0);
    add_test(OP_SCAN,      '0,          '0,    1'b0, 0, 1'b1);
    add_test(OP_STOP,      '0,          '0,    1'b0, 0, 1'b0);
    add_test(OP_READ,      `REG_CTRL,   '0,    1'b0, 0, 1'b0);
  endtask

  initial begin
    seed        = 32'h55e2_40ef;
    model_count = '0;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    quad_a      = 1'b0;
    quad_b      = 1'b0;
    build_tests();
    cycle_limit = tests.size() * LONGEST_OP + 1000;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (tests[i]) begin
      run_entry(tests[i]);
    end
    if (u_dut.u_props.fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      stop_with_failure();
    end
  end

endmodule

/* rgb_panel.f */
+incdir+rtl
rtl/panel_pkg.sv
rtl/quad_decoder.sv
rtl/panel_apb_regs.sv
rtl/frame_mem.sv
rtl/scan_sequencer.sv
rtl/panel_shifter.sv
rtl/rgb_panel_top.sv
sim/rgb_panel_props.sv
sim/rgb_panel_tb.sv

/* Bender.yml */
package:
  name: rgb_panel

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/panel_pkg.sv
      - rtl/quad_decoder.sv
      - rtl/panel_apb_regs.sv
      - rtl/frame_mem.sv
      - rtl/scan_sequencer.sv
      - rtl/panel_shifter.sv
      - rtl/rgb_panel_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/rgb_panel_props.sv
      - sim/rgb_panel_tb.sv
